// File: Bender.yml
package:
  name: ctrl_subsys

sources:
  # Package first, then the RTL leaves and the top level
  - logic/ctrl_bus_pkg.sv
  - logic/ctrl_bus_fsm.sv
  - logic/clint_timer.sv
  - logic/plic_arbiter.sv
  - logic/ctrl_subsys_top.sv
  - target: test
    files:
      - verif/ctrl_subsys_tb.sv

// File: logic/clint_timer.sv
// 32-bit mtime and mtimecmp for one hart; mtime advances every 2 clocks, writes win over the tick
`timescale 1ns/1ns
`default_nettype none

module clint_timer (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  ctrl_bus_pkg::tgt_access_t acc_i,
    output ctrl_bus_pkg::data_t       rdata_o,
    output logic                      timer_irq_o,
    output logic                      ipi_o
);

    logic                rtc_q;
    logic                rtc_dly_q;
    logic                rtc_rise;
    ctrl_bus_pkg::data_t mtime_q;
    ctrl_bus_pkg::data_t mtimecmp_q;
    logic                msip_q;
    logic                timer_irq_q;
    logic                ipi_q;
    ctrl_bus_pkg::data_t rd_val;

    // ========================================================================
    // Real-time tick
    // ========================================================================

    // Half-rate clock, edge detected like an external rtc
    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            rtc_q     <= 1'b0;
            rtc_dly_q <= 1'b0;
        end else begin
            rtc_q     <= ~rtc_q;
            rtc_dly_q <= rtc_q;
        end
    end

    assign rtc_rise = rtc_q && !rtc_dly_q;

    // ========================================================================
    // Timer and software interrupt registers
    // ========================================================================

    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            mtime_q     <= '0;
            mtimecmp_q  <= '1;
            msip_q      <= 1'b0;
            timer_irq_q <= 1'b0;
            ipi_q       <= 1'b0;
        end else begin
            // Software write overrides the tick
            if (acc_i.we && (acc_i.off == ctrl_bus_pkg::MTIME_OFF)) begin
                mtime_q <= acc_i.wdata;
            end else if (rtc_rise) begin
                mtime_q <= mtime_q + 32'd1;
            end
            if (acc_i.we && (acc_i.off == ctrl_bus_pkg::MTIMECMP_OFF)) begin
                mtimecmp_q <= acc_i.wdata;
            end
            // Only bit 0 of msip is implemented
            if (acc_i.we && (acc_i.off == ctrl_bus_pkg::MSIP_OFF)) begin
                msip_q <= acc_i.wdata[0];
            end
            // Registered interrupt levels
            timer_irq_q <= (mtime_q >= mtimecmp_q);
            ipi_q       <= msip_q;
        end
    end

    // Read mux, holes read 0
    always_comb begin
        case (acc_i.off)
            ctrl_bus_pkg::MSIP_OFF:     rd_val = {31'b0, msip_q};
            ctrl_bus_pkg::MTIMECMP_OFF: rd_val = mtimecmp_q;
            ctrl_bus_pkg::MTIME_OFF:    rd_val = mtime_q;
            default:                    rd_val = '0;
        endcase
    end

    // Data only on a read strobe
    assign rdata_o     = acc_i.re ? rd_val : '0;
    assign timer_irq_o = timer_irq_q;
    assign ipi_o       = ipi_q;

endmodule

`default_nettype wire

// File: logic/ctrl_bus_fsm.sv
// Fixed 2-clock request to response latency; requests during a transfer are dropped, no back-pressure
`timescale 1ns/1ns
`default_nettype none

module ctrl_bus_fsm (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      req_i,
    input  ctrl_bus_pkg::ctrl_req_t   req_data_i,
    output ctrl_bus_pkg::tgt_access_t clint_acc_o,
    output ctrl_bus_pkg::tgt_access_t plic_acc_o,
    input  ctrl_bus_pkg::data_t       clint_rdata_i,
    input  ctrl_bus_pkg::data_t       plic_rdata_i,
    output logic                      rsp_valid_o,
    output ctrl_bus_pkg::ctrl_rsp_t   rsp_o
);

    localparam int unsigned OFF_W = ctrl_bus_pkg::REGION_OFFSET_WIDTH;

    ctrl_bus_pkg::bus_state_e  state_q;
    ctrl_bus_pkg::bus_state_e  state_d;
    ctrl_bus_pkg::target_e     tgt_dec;
    ctrl_bus_pkg::target_e     tgt_q;
    ctrl_bus_pkg::ctrl_req_t   req_q;
    ctrl_bus_pkg::ctrl_rsp_t   rsp_d;
    ctrl_bus_pkg::ctrl_rsp_t   rsp_q;
    ctrl_bus_pkg::tgt_access_t acc;
    logic                      rsp_valid_q;
    logic                      accept;
    logic                      in_access;

    // ========================================================================
    // Region decode and sequencing
    // ========================================================================

    // Upper address bits select the region
    always_comb begin
        if (req_data_i.addr[31:OFF_W] == ctrl_bus_pkg::CLINT_BASE[31:OFF_W]) begin
            tgt_dec = ctrl_bus_pkg::TGT_CLINT;
        end else if (req_data_i.addr[31:OFF_W] == ctrl_bus_pkg::PLIC_BASE[31:OFF_W]) begin
            tgt_dec = ctrl_bus_pkg::TGT_PLIC;
        end else begin
            tgt_dec = ctrl_bus_pkg::TGT_NONE;
        end
    end

    // Only an idle sequencer takes a new request
    assign accept    = req_i && (state_q == ctrl_bus_pkg::ST_IDLE);
    assign in_access = (state_q == ctrl_bus_pkg::ST_ACCESS);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ctrl_bus_pkg::ST_IDLE:   if (req_i) state_d = ctrl_bus_pkg::ST_ACCESS;
            ctrl_bus_pkg::ST_ACCESS: state_d = ctrl_bus_pkg::ST_RESP;
            ctrl_bus_pkg::ST_RESP:   state_d = ctrl_bus_pkg::ST_IDLE;
            default:                 state_d = ctrl_bus_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            state_q     <= ctrl_bus_pkg::ST_IDLE;
            tgt_q       <= ctrl_bus_pkg::TGT_NONE;
            rsp_valid_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            // Response pulse one cycle after entering ST_RESP
            rsp_valid_q <= (state_q == ctrl_bus_pkg::ST_RESP);
            if (accept) begin
                tgt_q <= tgt_dec;
            end
        end
    end

    // Request and response payload
    always_ff @(posedge clk_i) begin
        if (accept) begin
            req_q <= req_data_i;
        end
        if (in_access) begin
            rsp_q <= rsp_d;
        end
    end

    // ========================================================================
    // Target strobes and read capture
    // ========================================================================

    always_comb begin
        acc.we      = in_access && req_q.we;
        acc.re      = in_access && !req_q.we;
        acc.off     = req_q.addr[OFF_W-1:0];
        acc.wdata   = req_q.wdata;
        clint_acc_o = acc;
        plic_acc_o  = acc;
        // Strobes only towards the decoded target
        if (tgt_q != ctrl_bus_pkg::TGT_CLINT) begin
            clint_acc_o.we = 1'b0;
            clint_acc_o.re = 1'b0;
        end
        if (tgt_q != ctrl_bus_pkg::TGT_PLIC) begin
            plic_acc_o.we = 1'b0;
            plic_acc_o.re = 1'b0;
        end
    end

    always_comb begin
        case (tgt_q)
            ctrl_bus_pkg::TGT_CLINT: begin
                rsp_d.rdata = clint_rdata_i;
                rsp_d.err   = 1'b0;
            end
            ctrl_bus_pkg::TGT_PLIC: begin
                rsp_d.rdata = plic_rdata_i;
                rsp_d.err   = 1'b0;
            end
            // Hole in the map
            default: begin
                rsp_d.rdata = '0;
                rsp_d.err   = 1'b1;
            end
        endcase
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_o       = rsp_q;

endmodule

`default_nettype wire

// File: logic/ctrl_bus_pkg.sv
// Control bus types and address map; 32-bit data, only two 16 MiB regions are decoded
`default_nettype none

package ctrl_bus_pkg;

    // ========================================================================
    // Basic bus types
    // ========================================================================

    // Width of the offset inside one region
    localparam int unsigned REGION_OFFSET_WIDTH = 24;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;

    // Request from the outside master, 65 bits
    typedef struct packed {
        logic  we;
        addr_t addr;
        data_t wdata;
    } ctrl_req_t;

    // Response back to the master, 33 bits
    typedef struct packed {
        data_t rdata;
        logic  err;
    } ctrl_rsp_t;

    // Per target access, 58 bits
    // At most one strobe set at a time
    typedef struct packed {
        logic                           we;
        logic                           re;
        logic [REGION_OFFSET_WIDTH-1:0] off;
        data_t                          wdata;
    } tgt_access_t;

    // Access sequencer states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACCESS,
        ST_RESP
    } bus_state_e;

    // Decoded target of a request
    typedef enum logic [1:0] {
        TGT_CLINT,
        TGT_PLIC,
        TGT_NONE
    } target_e;

    // ========================================================================
    // Address map
    // ========================================================================

    localparam addr_t CLINT_BASE = 32'h0200_0000;
    localparam addr_t PLIC_BASE  = 32'h0C00_0000;

    // CLINT registers
    localparam logic [REGION_OFFSET_WIDTH-1:0] MSIP_OFF     = 24'h00_0000;
    localparam logic [REGION_OFFSET_WIDTH-1:0] MTIMECMP_OFF = 24'h00_4000;
    localparam logic [REGION_OFFSET_WIDTH-1:0] MTIME_OFF    = 24'h00_BFF8;

    // PLIC registers, priority word per source at ID * 4
    localparam logic [REGION_OFFSET_WIDTH-1:0] PRIO_OFF      = 24'h00_0000;
    localparam logic [REGION_OFFSET_WIDTH-1:0] PENDING_OFF   = 24'h00_1000;
    localparam logic [REGION_OFFSET_WIDTH-1:0] ENABLE_OFF    = 24'h00_2000;
    localparam logic [REGION_OFFSET_WIDTH-1:0] THRESHOLD_OFF = 24'h20_0000;
    localparam logic [REGION_OFFSET_WIDTH-1:0] CLAIM_OFF     = 24'h20_0004;

    // Interrupt priority range
    localparam int unsigned PRI_WIDTH = 3;
    localparam int unsigned MAX_PRI   = 7;

endpackage

`default_nettype wire

// File: logic/ctrl_subsys_top.sv
// Single hart control subsystem, one bus master, SOURCE_NUM from 1 to 31 level sources
`timescale 1ns/1ns
`default_nettype none

module ctrl_subsys_top #(
    parameter int unsigned SOURCE_NUM = 8
) (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    req_i,
    input  ctrl_bus_pkg::ctrl_req_t req_data_i,
    output logic                    rsp_valid_o,
    output ctrl_bus_pkg::ctrl_rsp_t rsp_o,
    input  logic [SOURCE_NUM-1:0]   irq_sources_i,
    output logic                    timer_irq_o,
    output logic                    ipi_o,
    output logic                    ext_irq_o
);

    // ========================================================================
    // Target access paths
    // ========================================================================

    ctrl_bus_pkg::tgt_access_t clint_acc;
    ctrl_bus_pkg::tgt_access_t plic_acc;
    ctrl_bus_pkg::data_t       clint_rdata;
    ctrl_bus_pkg::data_t       plic_rdata;

    // Decoder and access sequencer
    ctrl_bus_fsm u_ctrl_bus_fsm (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .req_i         (req_i),
        .req_data_i    (req_data_i),
        .clint_acc_o   (clint_acc),
        .plic_acc_o    (plic_acc),
        .clint_rdata_i (clint_rdata),
        .plic_rdata_i  (plic_rdata),
        .rsp_valid_o   (rsp_valid_o),
        .rsp_o         (rsp_o)
    );

    // Timer and software interrupt
    clint_timer u_clint_timer (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .acc_i       (clint_acc),
        .rdata_o     (clint_rdata),
        .timer_irq_o (timer_irq_o),
        .ipi_o       (ipi_o)
    );

    // External interrupt controller
    plic_arbiter #(
        .SOURCE_NUM (SOURCE_NUM)
    ) u_plic_arbiter (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .acc_i         (plic_acc),
        .rdata_o       (plic_rdata),
        .irq_sources_i (irq_sources_i),
        .ext_irq_o     (ext_irq_o)
    );

endmodule

`default_nettype wire

// File: logic/plic_arbiter.sv
// One external target, level sources 1..SOURCE_NUM (1 to 31), priority and threshold clamp to MAX_PRI
`timescale 1ns/1ns
`default_nettype none

module plic_arbiter #(
    parameter int unsigned SOURCE_NUM = 8
) (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  ctrl_bus_pkg::tgt_access_t acc_i,
    output ctrl_bus_pkg::data_t       rdata_o,
    input  logic [SOURCE_NUM-1:0]     irq_sources_i,
    output logic                      ext_irq_o
);

    localparam int unsigned ID_WIDTH = $clog2(SOURCE_NUM + 1);
    localparam int unsigned PW       = ctrl_bus_pkg::PRI_WIDTH;
    localparam int unsigned OFF_W    = ctrl_bus_pkg::REGION_OFFSET_WIDTH;

    logic [PW-1:0]       prio_q [1:SOURCE_NUM];
    logic [SOURCE_NUM:1] enable_q;
    logic [SOURCE_NUM:1] pending_q;
    logic [SOURCE_NUM:1] pending_d;
    logic [SOURCE_NUM:1] in_service_q;
    logic [SOURCE_NUM:1] in_service_d;
    logic [PW-1:0]       threshold_q;
    logic [PW-1:0]       best_pri;
    logic [ID_WIDTH-1:0] best_id;
    logic                claim_rd;
    logic                complete_wr;
    logic                ext_irq_q;
    ctrl_bus_pkg::data_t rd_val;

    // Out-of-range writes saturate at the top priority
    function automatic logic [PW-1:0] clamp_pri(input ctrl_bus_pkg::data_t value);
        if (value > ctrl_bus_pkg::MAX_PRI) begin
            return PW'(ctrl_bus_pkg::MAX_PRI);
        end
        return value[PW-1:0];
    endfunction

    // Offset of the priority word of one source
    function automatic logic [OFF_W-1:0] prio_addr(input int unsigned id);
        return ctrl_bus_pkg::PRIO_OFF + OFF_W'(id * 4);
    endfunction

    // ========================================================================
    // Best-source search
    // ========================================================================

    // Strict compare keeps the lowest ID on ties, priority 0 never wins
    always_comb begin
        best_pri = '0;
        best_id  = '0;
        for (int unsigned i = 1; i <= SOURCE_NUM; i++) begin
            if (pending_q[i] && enable_q[i] && (prio_q[i] > best_pri)) begin
                best_pri = prio_q[i];
                best_id  = ID_WIDTH'(i);
            end
        end
    end

    // ========================================================================
    // Gateways and claim/complete
    // ========================================================================

    assign claim_rd    = acc_i.re && (acc_i.off == ctrl_bus_pkg::CLAIM_OFF);
    assign complete_wr = acc_i.we && (acc_i.off == ctrl_bus_pkg::CLAIM_OFF);

    always_comb begin
        // Level sets pending unless already in service
        pending_d    = pending_q | (irq_sources_i & ~in_service_q);
        in_service_d = in_service_q;
        for (int unsigned i = 1; i <= SOURCE_NUM; i++) begin
            // Claim moves the winner from pending to in service
            if (claim_rd && (best_id == ID_WIDTH'(i))) begin
                pending_d[i]    = 1'b0;
                in_service_d[i] = 1'b1;
            end
            // Completion by ID reopens the gateway
            if (complete_wr && (acc_i.wdata == 32'(i))) begin
                in_service_d[i] = 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            for (int unsigned i = 1; i <= SOURCE_NUM; i++) begin
                prio_q[i] <= '0;
            end
            enable_q     <= '0;
            threshold_q  <= '0;
            pending_q    <= '0;
            in_service_q <= '0;
            ext_irq_q    <= 1'b0;
        end else begin
            pending_q    <= pending_d;
            in_service_q <= in_service_d;
            ext_irq_q    <= (best_pri > threshold_q);
            if (acc_i.we) begin
                for (int unsigned i = 1; i <= SOURCE_NUM; i++) begin
                    if (acc_i.off == prio_addr(i)) begin
                        prio_q[i] <= clamp_pri(acc_i.wdata);
                    end
                end
                // Bit 0 is the reserved source 0
                if (acc_i.off == ctrl_bus_pkg::ENABLE_OFF) begin
                    enable_q <= acc_i.wdata[SOURCE_NUM:1];
                end
                if (acc_i.off == ctrl_bus_pkg::THRESHOLD_OFF) begin
                    threshold_q <= clamp_pri(acc_i.wdata);
                end
            end
        end
    end

    // Read mux, pending is read-only
    always_comb begin
        rd_val = '0;
        for (int unsigned i = 1; i <= SOURCE_NUM; i++) begin
            if (acc_i.off == prio_addr(i)) begin
                rd_val = ctrl_bus_pkg::data_t'(prio_q[i]);
            end
        end
        if (acc_i.off == ctrl_bus_pkg::PENDING_OFF) begin
            rd_val = ctrl_bus_pkg::data_t'({pending_q, 1'b0});
        end
        if (acc_i.off == ctrl_bus_pkg::ENABLE_OFF) begin
            rd_val = ctrl_bus_pkg::data_t'({enable_q, 1'b0});
        end
        if (acc_i.off == ctrl_bus_pkg::THRESHOLD_OFF) begin
            rd_val = ctrl_bus_pkg::data_t'(threshold_q);
        end
        // 0 when nothing is eligible
        if (acc_i.off == ctrl_bus_pkg::CLAIM_OFF) begin
            rd_val = ctrl_bus_pkg::data_t'(best_id);
        end
    end

    assign rdata_o   = acc_i.re ? rd_val : '0;
    assign ext_irq_o = ext_irq_q;

endmodule

`default_nettype wire

// File: sim.f
logic/ctrl_bus_pkg.sv
logic/ctrl_bus_fsm.sv
logic/clint_timer.sv
logic/plic_arbiter.sv
logic/ctrl_subsys_top.sv
verif/ctrl_subsys_tb.sv

// File: verif/ctrl_subsys_tb.sv
// Needs the project root as working directory for the vector file and fixes SOURCE_NUM at 8
`timescale 1ns/1ns
`default_nettype none

module ctrl_subsys_tb;

    localparam int unsigned SOURCE_NUM  = 8;
    localparam time         CLK_PERIOD  = 100;
    localparam int unsigned RSP_LATENCY = 2;
    localparam int unsigned RSP_TIMEOUT = 10;
    localparam int unsigned IRQ_TIMEOUT = 200;
    localparam int unsigned MAX_LINES   = 1000;

    // Vector operations from the first column of the file
    localparam int unsigned OP_WRITE     = 0;
    localparam int unsigned OP_READ      = 1;
    localparam int unsigned OP_SOURCES   = 2;
    localparam int unsigned OP_IRQ_CHECK = 3;
    localparam int unsigned OP_IRQ_WAIT  = 4;
    localparam int unsigned OP_READ_UP   = 5;

    logic                    clk;
    logic                    rst;
    logic                    req;
    ctrl_bus_pkg::ctrl_req_t req_data;
    logic                    rsp_valid;
    ctrl_bus_pkg::ctrl_rsp_t rsp;
    logic [SOURCE_NUM-1:0]   irq_sources;
    logic                    timer_irq;
    logic                    ipi;
    logic                    ext_irq;

    int unsigned             mismatch_errs;
    int unsigned             fail_errs;
    int unsigned             vec_count;
    ctrl_bus_pkg::data_t     last_rdata;

    ctrl_subsys_top #(
        .SOURCE_NUM (SOURCE_NUM)
    ) dut0 (
        .clk_i         (clk),
        .rst_i         (rst),
        .req_i         (req),
        .req_data_i    (req_data),
        .rsp_valid_o   (rsp_valid),
        .rsp_o         (rsp),
        .irq_sources_i (irq_sources),
        .timer_irq_o   (timer_irq),
        .ipi_o         (ipi),
        .ext_irq_o     (ext_irq)
    );

    // ========================================================================
    // Clock
    // ========================================================================

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Interrupt outputs packed as {ext, timer, ipi}
    function automatic logic [2:0] irq_levels();
        return {ext_irq, timer_irq, ipi};
    endfunction

    // ========================================================================
    // Bus access and interrupt waits
    // ========================================================================

    // One request strobe and an edge count up to the response pulse
    task automatic bus_access(input logic we, input ctrl_bus_pkg::addr_t addr,
                              input ctrl_bus_pkg::data_t wdata,
                              output ctrl_bus_pkg::data_t rdata, output logic err);
        int unsigned cycles;
        cycles = 0;
        @(negedge clk);
        // Previous pulse must be gone by now
        assert (!rsp_valid) else begin
            mismatch_errs++;
            $display("Mismatch at %0t ns: rsp_valid_o still high before request", $time);
        end
        req            = 1'b1;
        req_data.we    = we;
        req_data.addr  = addr;
        req_data.wdata = wdata;
        @(negedge clk);
        req = 1'b0;
        // Edges after the one that sampled req
        while (!rsp_valid && (cycles < RSP_TIMEOUT)) begin
            @(negedge clk);
            cycles++;
        end
        rdata = rsp.rdata;
        err   = rsp.err;
        assert (rsp_valid) else begin
            fail_errs++;
            $display("Timeout at %0t ns: no response for address %h", $time, addr);
        end
        if (rsp_valid) begin
            assert (cycles == RSP_LATENCY) else begin
                mismatch_errs++;
                $display("Mismatch at %0t ns: response after %0d clocks, expected %0d",
                         $time, cycles, RSP_LATENCY);
            end
        end
    endtask

    // Poll the interrupt levels until they match
    task automatic wait_irq(input logic [2:0] exp);
        int unsigned cycles;
        cycles = 0;
        @(negedge clk);
        while ((irq_levels() != exp) && (cycles < IRQ_TIMEOUT)) begin
            @(negedge clk);
            cycles++;
        end
        assert (irq_levels() == exp) else begin
            fail_errs++;
            $display("Timeout at %0t ns: interrupt levels stayed %b while waiting for %b",
                     $time, irq_levels(), exp);
        end
    endtask

    // ========================================================================
    // Vector execution
    // ========================================================================

    task automatic apply_vector(input logic [31:0] op, input logic [31:0] src,
                                input logic [31:0] addr, input logic [31:0] wdata,
                                input logic [31:0] exp, input logic err, input logic dc);
        ctrl_bus_pkg::data_t rdata;
        logic                rerr;
        case (op)
            OP_WRITE, OP_READ, OP_READ_UP: begin
                bus_access(op == OP_WRITE, addr, wdata, rdata, rerr);
                assert (rerr == err) else begin
                    mismatch_errs++;
                    $display("Mismatch at %0t ns: error flag %b at %h, expected %b",
                             $time, rerr, addr, err);
                end
                // Timer reads must advance
                if (op == OP_READ_UP) begin
                    assert (rdata > last_rdata) else begin
                        mismatch_errs++;
                        $display("Mismatch at %0t ns: read %h at %h, not above %h",
                                 $time, rdata, addr, last_rdata);
                    end
                end else if (!dc) begin
                    assert (rdata == exp) else begin
                        mismatch_errs++;
                        $display("Mismatch at %0t ns: data %h at %h, expected %h",
                                 $time, rdata, addr, exp);
                    end
                end
                if (op != OP_WRITE) begin
                    last_rdata = rdata;
                end
            end
            OP_SOURCES: begin
                @(negedge clk);
                irq_sources = src[SOURCE_NUM-1:0];
            end
            OP_IRQ_CHECK: begin
                @(negedge clk);
                assert (irq_levels() == exp[2:0]) else begin
                    mismatch_errs++;
                    $display("Mismatch at %0t ns: interrupt levels %b, expected %b",
                             $time, irq_levels(), exp[2:0]);
                end
            end
            OP_IRQ_WAIT: begin
                wait_irq(exp[2:0]);
            end
            default: begin
                fail_errs++;
                $display("Unknown operation %0d in vector file", op);
            end
        endcase
    endtask

    // Comment and blank lines give fewer than 7 fields and are skipped
    task automatic run_vectors(input int fd);
        logic [8*256-1:0] line;
        logic [31:0]      op;
        logic [31:0]      src;
        logic [31:0]      addr;
        logic [31:0]      wdata;
        logic [31:0]      exp;
        logic [31:0]      err;
        logic [31:0]      dc;
        int               code;
        int               nfields;
        int unsigned      lines;
        lines = 0;
        while (!$feof(fd) && (lines < MAX_LINES)) begin
            lines++;
            code = $fgets(line, fd);
            if (code != 0) begin
                nfields = $sscanf(line, "%h %h %h %h %h %h %h",
                                  op, src, addr, wdata, exp, err, dc);
                if (nfields == 7) begin
                    vec_count++;
                    apply_vector(op, src, addr, wdata, exp, err[0], dc[0]);
                end
            end
        end
    endtask

    // ========================================================================
    // Main sequence
    // ========================================================================

    initial begin
        int fd;
        rst           = 1'b0;
        req           = 1'b0;
        req_data      = '0;
        irq_sources   = '0;
        mismatch_errs = 0;
        fail_errs     = 0;
        vec_count     = 0;
        last_rdata    = '0;
        // Reset held over 4 rising edges and released on a falling edge
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        fd = $fopen("verif/ctrl_subsys_vectors.txt", "r");
        if (fd == 0) begin
            fail_errs++;
            $display("Could not open verif/ctrl_subsys_vectors.txt");
        end else begin
            run_vectors(fd);
            $fclose(fd);
            assert (vec_count > 0) else begin
                fail_errs++;
                $display("No vectors were found in the vector file");
            end
        end
        $display("Errors: %0d mismatches, %0d other failures, %0d vectors applied",
                 mismatch_errs, fail_errs, vec_count);
        if ((mismatch_errs == 0) && (fail_errs == 0)) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/ctrl_subsys_vectors.txt
// op src addr wdata exp err dc, all hex; dc 1 skips the data compare
// op 0 write, 1 read, 2 set sources, 3 check irq {ext,timer,ipi}, 4 wait irq, 5 read above last
3 00 00000000 00000000 00000000 0 0
1 00 10000000 00000000 00000000 1 0
0 00 30000000 12345678 00000000 1 0
1 00 02004000 00000000 FFFFFFFF 0 0
// Software interrupt
0 00 02000000 00000001 00000000 0 1
3 00 00000000 00000000 00000001 0 0
1 00 02000000 00000000 00000001 0 0
0 00 02000000 00000000 00000000 0 1
3 00 00000000 00000000 00000000 0 0
1 00 02000000 00000000 00000000 0 0
// Timer
1 00 0200BFF8 00000000 00000000 0 1
5 00 0200BFF8 00000000 00000000 0 1
0 00 0200BFF8 00000100 00000000 0 1
0 00 02004000 00000108 00000000 0 1
3 00 00000000 00000000 00000000 0 0
4 00 00000000 00000000 00000002 0 0
0 00 02004000 FFFFFFFF 00000000 0 1
3 00 00000000 00000000 00000000 0 0
// PLIC, sources 2 3 5 6 raised
2 36 00000000 00000000 00000000 0 0
0 00 0C000008 00000003 00000000 0 1
0 00 0C00000C 00000005 00000000 0 1
0 00 0C000014 00000005 00000000 0 1
0 00 0C000018 00000002 00000000 0 1
0 00 0C000004 00000007 00000000 0 1
1 00 0C00000C 00000000 00000005 0 0
1 00 0C001000 00000000 0000006C 0 0
0 00 0C200000 00000005 00000000 0 1
0 00 0C002000 000001FE 00000000 0 1
1 00 0C002000 00000000 000001FE 0 0
3 00 00000000 00000000 00000000 0 0
0 00 0C200000 00000004 00000000 0 1
3 00 00000000 00000000 00000004 0 0
1 00 0C200004 00000000 00000003 0 0
1 00 0C001000 00000000 00000064 0 0
1 00 0C200004 00000000 00000005 0 0
3 00 00000000 00000000 00000000 0 0
0 00 0C200004 00000003 00000000 0 1
4 00 00000000 00000000 00000004 0 0
1 00 0C200004 00000000 00000003 0 0
// Sources dropped, latched pending drains
2 00 00000000 00000000 00000000 0 0
0 00 0C200004 00000003 00000000 0 1
0 00 0C200004 00000005 00000000 0 1
0 00 0C200000 00000000 00000000 0 1
3 00 00000000 00000000 00000004 0 0
1 00 0C200004 00000000 00000002 0 0
1 00 0C200004 00000000 00000006 0 0
1 00 0C200004 00000000 00000000 0 0
3 00 00000000 00000000 00000000 0 0
1 00 0C001000 00000000 00000000 0 0
